// ==== source/stat_pkg.sv ====
`default_nettype none

package stat_pkg;

  localparam int PORT_COUNT        = 6;
  localparam int PORT_CLUSTERS     = 2;
  localparam int CEIL_PORT_COUNT   = 2 ** $clog2(PORT_COUNT);
  localparam int PORTS_PER_CLUSTER = CEIL_PORT_COUNT / PORT_CLUSTERS;
  localparam int PORT_WIDTH        = $clog2(CEIL_PORT_COUNT);
  localparam int LAST_SEL_BITS     = $clog2(PORTS_PER_CLUSTER);

  localparam int KEEP_WIDTH        = 8;
  localparam int BYTE_COUNT_WIDTH  = 32;
  localparam int FRAME_COUNT_WIDTH = 32;

  // Select register, replication, level 1, level 2
  localparam int SELECT_LATENCY    = 4;

  typedef logic [PORT_WIDTH-1:0]        port_t;
  typedef logic [BYTE_COUNT_WIDTH-1:0]  byte_count_t;
  typedef logic [FRAME_COUNT_WIDTH-1:0] frame_count_t; // Frames and drops
  typedef logic [KEEP_WIDTH-1:0]        keep_t;

endpackage

`default_nettype wire

// ==== source/stat_read_if.sv ====
`default_nettype none

interface stat_read_if;

  stat_pkg::port_t        port_select;
  stat_pkg::byte_count_t  byte_count;
  stat_pkg::frame_count_t frame_count;
  stat_pkg::frame_count_t drop_count;

  // Scanner side
  modport master (
    output port_select,
    input  byte_count,
    input  frame_count,
    input  drop_count
  );

  modport slave (
    input  port_select,
    output byte_count,
    output frame_count,
    output drop_count
  );

endinterface

`default_nettype wire

// ==== source/port_stat_counter.sv ====
`default_nettype none

module port_stat_counter (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           clear,
  input  wire stat_pkg::keep_t          keep,
  input  wire                           valid,
  input  wire                           ready,
  input  wire                           last,
  input  wire                           drop,
  output stat_pkg::byte_count_t         byte_count,
  output stat_pkg::frame_count_t        frame_count,
  output stat_pkg::frame_count_t        drop_count
);

  // Number of bytes carried by one beat
  function automatic stat_pkg::byte_count_t keep_bytes(input stat_pkg::keep_t k);
    stat_pkg::byte_count_t n;
    n = '0;
    for (int b = 0; b < stat_pkg::KEEP_WIDTH; b++) begin
      n = n + stat_pkg::byte_count_t'(k[b]);
    end
    return n;
  endfunction

  logic beat;

  assign beat = valid && ready; // Transfer on the monitored stream

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      byte_count <= '0;
      frame_count <= '0;
      drop_count <= '0;
    end else begin
      if (beat) begin
        byte_count <= byte_count + keep_bytes(keep); // Wraps
        if (last) begin
          frame_count <= frame_count + 1'b1;
        end
      end
      if (drop) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/stat_select.sv ====
`default_nettype none

module stat_select (
  input  wire                                            clk,
  input  wire                                            rst_n,
  input  wire [stat_pkg::PORT_COUNT-1:0]                 port_clear,
  input  wire stat_pkg::keep_t [stat_pkg::PORT_COUNT-1:0] monitor_keep,
  input  wire [stat_pkg::PORT_COUNT-1:0]                 monitor_valid,
  input  wire [stat_pkg::PORT_COUNT-1:0]                 monitor_ready,
  input  wire [stat_pkg::PORT_COUNT-1:0]                 monitor_last,
  input  wire [stat_pkg::PORT_COUNT-1:0]                 monitor_drop,
  stat_read_if.slave                                     rd
);

  stat_pkg::keep_t [stat_pkg::PORT_COUNT-1:0] keep_r;
  logic [stat_pkg::PORT_COUNT-1:0]            valid_r;
  logic [stat_pkg::PORT_COUNT-1:0]            ready_r;
  logic [stat_pkg::PORT_COUNT-1:0]            last_r;
  logic [stat_pkg::PORT_COUNT-1:0]            drop_r;

  stat_pkg::port_t                                                 sel_r;
  logic [stat_pkg::PORT_CLUSTERS-1:0][stat_pkg::LAST_SEL_BITS-1:0] sel_rr;

  stat_pkg::byte_count_t  [stat_pkg::CEIL_PORT_COUNT-1:0] byte_int;
  stat_pkg::frame_count_t [stat_pkg::CEIL_PORT_COUNT-1:0] frame_int;
  stat_pkg::frame_count_t [stat_pkg::CEIL_PORT_COUNT-1:0] drop_int;
  stat_pkg::byte_count_t  [stat_pkg::CEIL_PORT_COUNT-1:0] byte_int_r;
  stat_pkg::frame_count_t [stat_pkg::CEIL_PORT_COUNT-1:0] frame_int_r;
  stat_pkg::frame_count_t [stat_pkg::CEIL_PORT_COUNT-1:0] drop_int_r;

  stat_pkg::byte_count_t  [stat_pkg::PORT_CLUSTERS-1:0] byte_rr;
  stat_pkg::frame_count_t [stat_pkg::PORT_CLUSTERS-1:0] frame_rr;
  stat_pkg::frame_count_t [stat_pkg::PORT_CLUSTERS-1:0] drop_rr;

  always_ff @(posedge clk) begin
    keep_r <= monitor_keep;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_r <= '0;
      ready_r <= '0;
      last_r <= '0;
      drop_r <= '0;
    end else begin
      valid_r <= monitor_valid & ~port_clear; // No counting during a clear
      ready_r <= monitor_ready;
      last_r <= monitor_last;
      drop_r <= monitor_drop;
    end
  end

  for (genvar i = 0; i < stat_pkg::PORT_COUNT; i++) begin : g_counter
    port_stat_counter u_counter (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear       (port_clear[i]),
      .keep        (keep_r[i]),
      .valid       (valid_r[i]),
      .ready       (ready_r[i]),
      .last        (last_r[i]),
      .drop        (drop_r[i]),
      .byte_count  (byte_int[i]),
      .frame_count (frame_int[i]),
      .drop_count  (drop_int[i])
    );
  end

  // Unused ports read as zero
  for (genvar i = stat_pkg::PORT_COUNT; i < stat_pkg::CEIL_PORT_COUNT; i++) begin : g_pad
    assign byte_int[i] = '0;
    assign frame_int[i] = '0;
    assign drop_int[i] = '0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel_r <= '0;
      sel_rr <= '0;
    end else begin
      sel_r <= rd.port_select;
      sel_rr <= {stat_pkg::PORT_CLUSTERS{sel_r[stat_pkg::LAST_SEL_BITS-1:0]}}; // One per cluster
    end
  end

  always_ff @(posedge clk) begin
    byte_int_r <= byte_int;
    frame_int_r <= frame_int;
    drop_int_r <= drop_int;
  end

  for (genvar j = 0; j < stat_pkg::PORT_CLUSTERS; j++) begin : g_level1
    int unsigned idx;

    assign idx = j * stat_pkg::PORTS_PER_CLUSTER + int'(sel_rr[j]); // Port within cluster

    always_ff @(posedge clk) begin
      byte_rr[j] <= byte_int_r[idx];
      frame_rr[j] <= frame_int_r[idx];
      drop_rr[j] <= drop_int_r[idx];
    end
  end

  // Cluster pick by the upper select bits
  always_ff @(posedge clk) begin
    rd.byte_count <= byte_rr[sel_r[stat_pkg::PORT_WIDTH-1:stat_pkg::LAST_SEL_BITS]];
    rd.frame_count <= frame_rr[sel_r[stat_pkg::PORT_WIDTH-1:stat_pkg::LAST_SEL_BITS]];
    rd.drop_count <= drop_rr[sel_r[stat_pkg::PORT_WIDTH-1:stat_pkg::LAST_SEL_BITS]];
  end

endmodule

`default_nettype wire

// ==== source/stat_scanner.sv ====
`default_nettype none

module stat_scanner (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              scan_start,
  input  wire                              clear_on_read,
  stat_read_if.master                      rd,
  output logic [stat_pkg::PORT_COUNT-1:0]  port_clear,
  output logic                             scan_valid,
  output stat_pkg::port_t                  scan_port,
  output stat_pkg::byte_count_t            scan_bytes,
  output stat_pkg::frame_count_t           scan_frames,
  output stat_pkg::frame_count_t           scan_drops,
  output logic                             scan_busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_settle,
    st_capture
  } state_t;

  state_t                                        state;
  logic                                          clear_latched;
  logic [$clog2(stat_pkg::SELECT_LATENCY+1)-1:0] settle_cnt;
  stat_pkg::port_t                               port_sel;
  logic                                          settle_done;
  logic                                          last_port;

  assign rd.port_select = port_sel; // Held for the whole settle
  assign settle_done = settle_cnt == $bits(settle_cnt)'(stat_pkg::SELECT_LATENCY - 1);
  assign last_port = port_sel == stat_pkg::port_t'(stat_pkg::PORT_COUNT - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      clear_latched <= 1'b0;
      settle_cnt <= '0;
      port_sel <= '0;
      scan_busy <= 1'b0;
      scan_valid <= 1'b0;
      port_clear <= '0;
    end else begin
      scan_valid <= 1'b0;
      port_clear <= '0;
      case (state)
        st_idle: begin
          if (scan_start && !scan_busy) begin
            state <= st_settle;
            scan_busy <= 1'b1;
            clear_latched <= clear_on_read; // Sampled once per scan
            port_sel <= '0;
            settle_cnt <= '0;
          end else begin
            scan_busy <= 1'b0; // Drops one cycle after the last strobe
          end
        end
        st_settle: begin
          if (settle_done) begin
            state <= st_capture;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        st_capture: begin
          scan_valid <= 1'b1;
          port_clear[port_sel] <= clear_latched;
          settle_cnt <= '0;
          if (last_port) begin
            state <= st_idle;
          end else begin
            port_sel <= port_sel + 1'b1;
            state <= st_settle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Counts of the current port
  always_ff @(posedge clk) begin
    if (state == st_capture) begin
      scan_port <= port_sel;
      scan_bytes <= rd.byte_count;
      scan_frames <= rd.frame_count;
      scan_drops <= rd.drop_count;
    end
  end

endmodule

`default_nettype wire

// ==== source/port_stats_top.sv ====
`default_nettype none

module port_stats_top (
  input  wire                                            clk,
  input  wire                                            rst_n,

  input  wire stat_pkg::keep_t [stat_pkg::PORT_COUNT-1:0] monitor_keep,
  input  wire [stat_pkg::PORT_COUNT-1:0]                 monitor_valid,
  input  wire [stat_pkg::PORT_COUNT-1:0]                 monitor_ready,
  input  wire [stat_pkg::PORT_COUNT-1:0]                 monitor_last,
  input  wire [stat_pkg::PORT_COUNT-1:0]                 monitor_drop,

  input  wire                                            scan_start,
  input  wire                                            clear_on_read,

  output logic                                           scan_valid,
  output stat_pkg::port_t                                scan_port,
  output stat_pkg::byte_count_t                          scan_bytes,
  output stat_pkg::frame_count_t                         scan_frames,
  output stat_pkg::frame_count_t                         scan_drops,
  output logic                                           scan_busy
);

  logic [stat_pkg::PORT_COUNT-1:0] port_clear; // One pulse per cleared port

  stat_read_if rd_if ();

  // Counters and the pipelined port select
  stat_select u_select (
    .clk           (clk),
    .rst_n         (rst_n),
    .port_clear    (port_clear),
    .monitor_keep  (monitor_keep),
    .monitor_valid (monitor_valid),
    .monitor_ready (monitor_ready),
    .monitor_last  (monitor_last),
    .monitor_drop  (monitor_drop),
    .rd            (rd_if.slave)
  );

  // Walks the ports after scan_start
  stat_scanner u_scanner (
    .clk           (clk),
    .rst_n         (rst_n),
    .scan_start    (scan_start),
    .clear_on_read (clear_on_read),
    .rd            (rd_if.master),
    .port_clear    (port_clear),
    .scan_valid    (scan_valid),
    .scan_port     (scan_port),
    .scan_bytes    (scan_bytes),
    .scan_frames   (scan_frames),
    .scan_drops    (scan_drops),
    .scan_busy     (scan_busy)
  );

endmodule

`default_nettype wire

// ==== tests/port_stats_tb.sv ====
`default_nettype none

module port_stats_tb;

  localparam int TRAFFIC_CYCLES = 300 + 100 + 100;
  localparam int SCAN_COUNT     = 6;
  localparam int TIMEOUT_CYCLES = TRAFFIC_CYCLES
                                  + SCAN_COUNT * stat_pkg::PORT_COUNT
                                    * (stat_pkg::SELECT_LATENCY + 2)
                                  + 400; // Idle gaps and scan overhead

  logic clk = 1'b0;
  logic rst_n;

  stat_pkg::keep_t [stat_pkg::PORT_COUNT-1:0] monitor_keep;
  logic [stat_pkg::PORT_COUNT-1:0]            monitor_valid;
  logic [stat_pkg::PORT_COUNT-1:0]            monitor_ready;
  logic [stat_pkg::PORT_COUNT-1:0]            monitor_last;
  logic [stat_pkg::PORT_COUNT-1:0]            monitor_drop;
  logic                                       scan_start;
  logic                                       clear_on_read;

  logic                   scan_valid;
  stat_pkg::port_t        scan_port;
  stat_pkg::byte_count_t  scan_bytes;
  stat_pkg::frame_count_t scan_frames;
  stat_pkg::frame_count_t scan_drops;
  logic                   scan_busy;

  // Reference counts per port
  stat_pkg::byte_count_t  byte_model  [stat_pkg::PORT_COUNT];
  stat_pkg::frame_count_t frame_model [stat_pkg::PORT_COUNT];
  stat_pkg::frame_count_t drop_model  [stat_pkg::PORT_COUNT];

  int   errors      = 0;
  int   cycle_count = 0;
  int   pulse_count = 0;
  logic scan_clear  = 1'b0;

  port_stats_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .monitor_keep  (monitor_keep),
    .monitor_valid (monitor_valid),
    .monitor_ready (monitor_ready),
    .monitor_last  (monitor_last),
    .monitor_drop  (monitor_drop),
    .scan_start    (scan_start),
    .clear_on_read (clear_on_read),
    .scan_valid    (scan_valid),
    .scan_port     (scan_port),
    .scan_bytes    (scan_bytes),
    .scan_frames   (scan_frames),
    .scan_drops    (scan_drops),
    .scan_busy     (scan_busy)
  );

  always #20 clk = ~clk;

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %0h got %0h", $time, what, expected, actual);
    end
  endtask

  // Apply the counting rules to the beat now on the inputs
  task automatic count_beat;
    for (int p = 0; p < stat_pkg::PORT_COUNT; p++) begin
      if (monitor_valid[p] && monitor_ready[p]) begin
        byte_model[p] = byte_model[p] + stat_pkg::byte_count_t'($countones(monitor_keep[p]));
        if (monitor_last[p]) begin
          frame_model[p] = frame_model[p] + 1;
        end
      end
      if (monitor_drop[p]) begin
        drop_model[p] = drop_model[p] + 1;
      end
    end
  endtask

  task automatic drive_random(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      #1;
      for (int p = 0; p < stat_pkg::PORT_COUNT; p++) begin
        monitor_keep[p] = stat_pkg::keep_t'($urandom);
        monitor_valid[p] = 1'($urandom_range(0, 1));
        monitor_ready[p] = 1'($urandom_range(0, 1));
        monitor_last[p] = ($urandom_range(0, 3) == 0);
        monitor_drop[p] = ($urandom_range(0, 7) == 0);
      end
      count_beat();
    end
  endtask

  // Only one of valid and ready high on each beat
  task automatic drive_half_beats(input int cycles);
    logic v;
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      #1;
      for (int p = 0; p < stat_pkg::PORT_COUNT; p++) begin
        v = 1'($urandom_range(0, 1));
        monitor_keep[p] = stat_pkg::keep_t'($urandom);
        monitor_valid[p] = v;
        monitor_ready[p] = !v;
        monitor_last[p] = 1'($urandom_range(0, 1));
        monitor_drop[p] = 1'b0;
      end
      count_beat();
    end
  endtask

  task automatic stop_traffic;
    @(posedge clk);
    #1;
    monitor_valid = '0;
    monitor_ready = '0;
    monitor_last = '0;
    monitor_drop = '0;
    repeat (4) @(posedge clk);
  endtask

  task automatic run_scan(input logic clear, input logic start_while_busy);
    @(posedge clk);
    #1;
    pulse_count = 0;
    scan_clear = clear;
    scan_start = 1'b1;
    clear_on_read = clear;
    @(posedge clk);
    #1;
    scan_start = 1'b0;
    clear_on_read = 1'b0;
    @(negedge clk);
    compare_value("scan_busy after scan_start", 1, scan_busy);
    if (start_while_busy) begin
      repeat (10) @(posedge clk);
      #1;
      scan_start = 1'b1; // Must be ignored
      @(posedge clk);
      #1;
      scan_start = 1'b0;
    end
    while (pulse_count < stat_pkg::PORT_COUNT) begin
      @(posedge clk);
    end
    @(negedge clk);
    compare_value("scan_busy after last strobe", 0, scan_busy);
    repeat (8) @(posedge clk);
    compare_value("scan_valid pulses per scan", stat_pkg::PORT_COUNT, pulse_count);
  endtask

  // Strobe checker sampling outputs mid cycle
  always @(negedge clk) begin
    if (rst_n === 1'b1 && scan_valid === 1'b1) begin
      compare_value("scan_busy during strobe", 1, scan_busy);
      compare_value("scan_port order", pulse_count, 32'(scan_port));
      if (pulse_count < stat_pkg::PORT_COUNT) begin
        compare_value("scan_bytes", byte_model[pulse_count], scan_bytes);
        compare_value("scan_frames", frame_model[pulse_count], scan_frames);
        compare_value("scan_drops", drop_model[pulse_count], scan_drops);
        if (scan_clear) begin
          byte_model[pulse_count] = '0;
          frame_model[pulse_count] = '0;
          drop_model[pulse_count] = '0;
        end
      end
      pulse_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles with %0d errors", cycle_count, errors);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h31916bcf));
    rst_n = 1'b0;
    monitor_keep = '0;
    monitor_valid = '0;
    monitor_ready = '0;
    monitor_last = '0;
    monitor_drop = '0;
    scan_start = 1'b0;
    clear_on_read = 1'b0;
    for (int p = 0; p < stat_pkg::PORT_COUNT; p++) begin
      byte_model[p] = '0;
      frame_model[p] = '0;
      drop_model[p] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    run_scan(1'b0, 1'b0); // All zero after reset

    drive_random(300);
    stop_traffic();
    run_scan(1'b0, 1'b1); // Extra start while busy

    drive_half_beats(100);
    stop_traffic();
    run_scan(1'b0, 1'b0);

    run_scan(1'b1, 1'b0); // Clear on read
    run_scan(1'b0, 1'b0);

    drive_random(100);
    stop_traffic();
    run_scan(1'b0, 1'b0); // Counting resumes from zero

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
source/stat_pkg.sv
source/stat_read_if.sv
source/port_stat_counter.sv
source/stat_select.sv
source/stat_scanner.sv
source/port_stats_top.sv
tests/port_stats_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = port_stats_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
